//--- project.f
source/isaPkg.sv
source/pipePkg.sv
source/hazardIf.sv
source/regFile.sv
source/alu.sv
source/controlUnit.sv
source/hazardUnit.sv
source/pipeDatapath.sv
source/cpuTop.sv
tb/cpuTop_props.sv
tb/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
    -f project.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
if [ -f sim.log ] && ! grep -q "Simulation failed" sim.log \
    && grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import isaPkg::*, pipePkg::*; (
    input  logic [wordWidth-1:0] a,
    input  logic [wordWidth-1:0] b,
    input  aluOpE                op,
    output logic [wordWidth-1:0] result,
    output logic                 isZero
);

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluPassB: begin
                result = b;  // lhi, immediate already shifted
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // branches subtract, so zero means equal
    assign isZero = (result == '0);

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit import isaPkg::*, pipePkg::*; (
    input  logic [wordWidth-1:0] instr,
    output ctrlWord              ctrl,
    output logic                 usesRs,
    output logic                 usesRt
);

    opcodeE opcode;
    funcE   func;

    assign opcode = opcodeE'(instr[opHi:opLo]);
    assign func   = funcE'(instr[funcHi:funcLo]);

    always_comb begin
        ctrl       = '0;
        ctrl.valid = 1'b1;
        ctrl.dest  = instr[rtHi:rtLo];   // immediate forms write rt
        usesRs     = 1'b0;
        usesRt     = 1'b0;
        case (opcode)
            opRtype: begin
                ctrl.dest = instr[rdHi:rdLo];
                usesRs    = 1'b1;
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        usesRt        = 1'b1;
                        case (func)
                            fnSub:   ctrl.aluOp = aluSub;
                            fnAnd:   ctrl.aluOp = aluAnd;
                            fnOrr:   ctrl.aluOp = aluOr;
                            default: ctrl.aluOp = aluAdd;
                        endcase
                    end
                    fnWwd: ctrl.isWwd = 1'b1;
                    fnHlt: begin
                        ctrl.isHalt = 1'b1;
                        usesRs      = 1'b0;
                    end
                    default: begin
                        ctrl   = '0;  // unknown func
                        usesRs = 1'b0;
                    end
                endcase
            end
            opAdi, opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = (opcode == opLwd);
                ctrl.memToReg  = (opcode == opLwd);
                usesRs         = 1'b1;
            end
            opLhi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
            end
            opSwd: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                usesRs         = 1'b1;
                usesRt         = 1'b1;  // store data
            end
            opBne, opBeq: begin
                ctrl.isBranch      = 1'b1;
                ctrl.branchOnEqual = (opcode == opBeq);
                ctrl.aluOp         = aluSub;
                usesRs             = 1'b1;
                usesRt             = 1'b1;
            end
            opJmp:   ctrl.isJump = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop import isaPkg::*, pipePkg::*; #(
    parameter logic [wordWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    output logic [wordWidth-1:0] iAddr,
    input  logic [wordWidth-1:0] iData,
    output logic                 dRead,
    output logic                 dWrite,
    output logic [wordWidth-1:0] dAddr,
    output logic [wordWidth-1:0] dWdata,
    input  logic [wordWidth-1:0] dRdata,
    output logic [wordWidth-1:0] outputPort,
    output logic                 outputValid,
    output logic [wordWidth-1:0] numInst,
    output logic                 halted
);

    logic [wordWidth-1:0] instrId;
    ctrlWord              ctrlId;
    regIdx                rdIdxA, rdIdxB, wrIdx;
    logic [wordWidth-1:0] rdDataA, rdDataB, wrData;
    logic                 wrEn;
    logic [wordWidth-1:0] aluA, aluB, aluResult;
    aluOpE                aluOp;
    logic                 aluZero;

    hazardIf hzBus ();

    pipeDatapath #(.resetPc(resetPc)) u_datapath (
        .clk, .rstN, .hz(hzBus.datapath),
        .instrId, .ctrlId,
        .rdIdxA, .rdIdxB, .rdDataA, .rdDataB,
        .wrIdx, .wrData, .wrEn,
        .aluA, .aluB, .aluOp, .aluResult, .aluZero,
        .iAddr, .iData, .dRead, .dWrite, .dAddr, .dWdata, .dRdata,
        .outputPort, .outputValid, .numInst, .halted
    );

    // register-use flags go straight onto the hazard bus
    controlUnit u_controlUnit (
        .instr(instrId), .ctrl(ctrlId),
        .usesRs(hzBus.idUsesRs), .usesRt(hzBus.idUsesRt)
    );

    hazardUnit u_hazardUnit (.hz(hzBus.hazard));

    regFile u_regFile (
        .clk, .rstN, .rdIdxA, .rdIdxB, .rdDataA, .rdDataB, .wrIdx, .wrData, .wrEn
    );

    alu u_alu (.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .isZero(aluZero));

endmodule

`default_nettype wire

//--- source/hazardIf.sv
`timescale 1ns/100ps
`default_nettype none

interface hazardIf import isaPkg::*, pipePkg::*; ();

    regIdx  idRs, idRt;
    logic   idUsesRs, idUsesRt;     // from the decoder
    regIdx  exRs, exRt, exRd;
    logic   exRegWrite, exMemRead;
    regIdx  memRd, wbRd;
    logic   memRegWrite, wbRegWrite;
    logic   stall;
    fwdSelE fwdA, fwdB;

    modport datapath (
        output idRs, idRt, exRs, exRt, exRd, exRegWrite, exMemRead,
        output memRd, memRegWrite, wbRd, wbRegWrite,
        input  stall, fwdA, fwdB
    );

    modport hazard (
        input  idRs, idRt, idUsesRs, idUsesRt, exRs, exRt, exRd, exRegWrite, exMemRead,
        input  memRd, memRegWrite, wbRd, wbRegWrite,
        output stall, fwdA, fwdB
    );

endinterface

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit import isaPkg::*, pipePkg::*; (
    hazardIf.hazard hz
);

    logic rsHit;
    logic rtHit;

    // newest producer wins, so mem is checked before wb
    function automatic fwdSelE pickFwd(
        input regIdx src,
        input logic  memWr,
        input regIdx memRd,
        input logic  wbWr,
        input regIdx wbRd
    );
        if (memWr && memRd == src) begin
            return fwdMem;
        end else if (wbWr && wbRd == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    // load in ex, consumer in id
    assign rsHit = hz.idUsesRs && (hz.idRs == hz.exRd);
    assign rtHit = hz.idUsesRt && (hz.idRt == hz.exRd);
    assign hz.stall = hz.exMemRead && hz.exRegWrite && (rsHit || rtHit);

    assign hz.fwdA = pickFwd(hz.exRs, hz.memRegWrite, hz.memRd, hz.wbRegWrite, hz.wbRd);
    assign hz.fwdB = pickFwd(hz.exRt, hz.memRegWrite, hz.memRd, hz.wbRegWrite, hz.wbRd);

endmodule

`default_nettype wire

//--- source/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordWidth = 16;

    typedef logic [1:0] regIdx;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcE;

    // instruction field positions
    localparam int opHi = 15;
    localparam int opLo = 12;
    localparam int rsHi = 11;
    localparam int rsLo = 10;
    localparam int rtHi = 9;
    localparam int rtLo = 8;
    localparam int rdHi = 7;
    localparam int rdLo = 6;
    localparam int funcHi = 5;
    localparam int funcLo = 0;
    localparam int immHi = 7;
    localparam int immLo = 0;
    localparam int immWidth = immHi - immLo + 1;
    localparam int targetHi = 11; // jump target, low bits of pc
    localparam int targetLo = 0;

endpackage

`default_nettype wire

//--- source/pipeDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module pipeDatapath import isaPkg::*, pipePkg::*; #(
    parameter logic [wordWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    hazardIf.datapath            hz,
    output logic [wordWidth-1:0] instrId,
    input  ctrlWord              ctrlId,
    output regIdx                rdIdxA,
    output regIdx                rdIdxB,
    input  logic [wordWidth-1:0] rdDataA,
    input  logic [wordWidth-1:0] rdDataB,
    output regIdx                wrIdx,
    output logic [wordWidth-1:0] wrData,
    output logic                 wrEn,
    output logic [wordWidth-1:0] aluA,
    output logic [wordWidth-1:0] aluB,
    output aluOpE                aluOp,
    input  logic [wordWidth-1:0] aluResult,
    input  logic                 aluZero,
    output logic [wordWidth-1:0] iAddr,
    input  logic [wordWidth-1:0] iData,
    output logic                 dRead,
    output logic                 dWrite,
    output logic [wordWidth-1:0] dAddr,
    output logic [wordWidth-1:0] dWdata,
    input  logic [wordWidth-1:0] dRdata,
    output logic [wordWidth-1:0] outputPort,
    output logic                 outputValid,
    output logic [wordWidth-1:0] numInst,
    output logic                 halted
);

    // r-type with an unused func, decodes to a bubble
    localparam logic [wordWidth-1:0] bubbleWord = {opRtype, {(wordWidth - 4){1'b1}}};

    logic [wordWidth-1:0] pc, pcPlus1;
    logic                 ifIdValid;
    logic [wordWidth-1:0] ifIdInstr, ifIdPcPlus1;
    logic [wordWidth-1:0] immSext, immId, jumpTarget, branchTarget;
    ctrlWord              idExCtrl;
    regIdx                idExRs, idExRt;
    logic [wordWidth-1:0] idExA, idExB, idExImm, idExTarget;
    logic [wordWidth-1:0] opA, opB, memFwd;
    logic                 branchTaken;
    ctrlWord              exMemCtrl;
    logic [wordWidth-1:0] exMemAlu, exMemData;
    ctrlWord              memWbCtrl;
    logic [wordWidth-1:0] memWbResult, memWbData;
    logic                 haltReg;

    function automatic logic [wordWidth-1:0] fwdMux(
        input fwdSelE               sel,
        input logic [wordWidth-1:0] regVal,
        input logic [wordWidth-1:0] memVal,
        input logic [wordWidth-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign pcPlus1 = pc + 1'b1;
    assign iAddr   = pc;

    // id
    assign instrId      = ifIdValid ? ifIdInstr : bubbleWord;
    assign rdIdxA       = instrId[rsHi:rsLo];
    assign rdIdxB       = instrId[rtHi:rtLo];
    assign immSext      = {{(wordWidth - immWidth){instrId[immHi]}}, instrId[immHi:immLo]};
    assign immId        = (ctrlId.aluOp == aluPassB)
                        ? {instrId[immHi:immLo], {(wordWidth - immWidth){1'b0}}} : immSext;
    assign jumpTarget   = {ifIdPcPlus1[wordWidth-1:targetHi+1], instrId[targetHi:targetLo]};
    assign branchTarget = ifIdPcPlus1 + immSext;

    // ex
    assign memFwd      = exMemCtrl.memToReg ? dRdata : exMemAlu; // load data is ready in mem
    assign opA         = fwdMux(hz.fwdA, idExA, memFwd, wrData);
    assign opB         = fwdMux(hz.fwdB, idExB, memFwd, wrData);
    assign aluA        = opA;
    assign aluB        = idExCtrl.aluSrcImm ? idExImm : opB;
    assign aluOp       = idExCtrl.aluOp;
    assign branchTaken = idExCtrl.isBranch && (idExCtrl.branchOnEqual == aluZero);

    assign hz.idRs        = rdIdxA;
    assign hz.idRt        = rdIdxB;
    assign hz.exRs        = idExRs;
    assign hz.exRt        = idExRt;
    assign hz.exRd        = idExCtrl.dest;
    assign hz.exRegWrite  = idExCtrl.regWrite;
    assign hz.exMemRead   = idExCtrl.memRead;
    assign hz.memRd       = exMemCtrl.dest;
    assign hz.memRegWrite = exMemCtrl.regWrite;
    assign hz.wbRd        = memWbCtrl.dest;
    assign hz.wbRegWrite  = memWbCtrl.regWrite;

    // mem, quiet once halted
    assign dRead  = exMemCtrl.memRead && !halted;
    assign dWrite = exMemCtrl.memWrite && !halted;
    assign dAddr  = exMemAlu;
    assign dWdata = exMemData;

    // wb
    assign wrIdx       = memWbCtrl.dest;
    assign wrData      = memWbResult;
    assign wrEn        = memWbCtrl.regWrite;
    assign outputPort  = memWbData;
    assign outputValid = memWbCtrl.isWwd;
    assign halted      = haltReg || memWbCtrl.isHalt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc        <= resetPc;
            ifIdValid <= 1'b0;
            idExCtrl  <= '0;
            exMemCtrl <= '0;
            memWbCtrl <= '0;
            haltReg   <= 1'b0;
            numInst   <= '0;
        end else begin
            if (memWbCtrl.valid && !haltReg) begin
                numInst <= numInst + 1'b1;  // hlt itself counts once
            end
            if (memWbCtrl.isHalt) begin
                haltReg <= 1'b1;
            end
            if (!halted) begin
                if (branchTaken) begin
                    pc <= idExTarget;
                end else if (ctrlId.isJump) begin
                    pc <= jumpTarget;
                end else if (!hz.stall) begin
                    pc <= pcPlus1;
                end
                if (branchTaken || ctrlId.isJump) begin
                    ifIdValid <= 1'b0;
                end else if (!hz.stall) begin
                    ifIdValid <= 1'b1;
                end
                idExCtrl  <= (branchTaken || hz.stall) ? '0 : ctrlId;
                exMemCtrl <= idExCtrl;
                memWbCtrl <= exMemCtrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            if (!hz.stall) begin
                ifIdInstr   <= iData;
                ifIdPcPlus1 <= pcPlus1;
            end
            idExRs      <= rdIdxA;
            idExRt      <= rdIdxB;
            idExA       <= rdDataA;
            idExB       <= rdDataB;
            idExImm     <= immId;
            idExTarget  <= branchTarget;
            exMemAlu    <= aluResult;
            exMemData   <= idExCtrl.isWwd ? opA : opB; // wwd sends rs, swd stores rt
            memWbResult <= memFwd;
            memWbData   <= exMemData;
        end
    end

endmodule

`default_nettype wire

//--- source/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassB // lhi
    } aluOpE;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelE;

    // all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        aluOpE aluOp;
        logic  isBranch;
        logic  branchOnEqual;
        logic  isJump;
        logic  isWwd;
        logic  isHalt;
        regIdx dest;
        logic  valid;
    } ctrlWord;

endpackage

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile import isaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  regIdx                rdIdxA,
    input  regIdx                rdIdxB,
    output logic [wordWidth-1:0] rdDataA,
    output logic [wordWidth-1:0] rdDataB,
    input  regIdx                wrIdx,
    input  logic [wordWidth-1:0] wrData,
    input  logic                 wrEn
);

    logic [wordWidth-1:0] regs [4];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // write-through, wb result seen in id the same cycle
    assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
    assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

`default_nettype wire

//--- tb/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb import isaPkg::*; ();

    logic                 clk;
    logic                 rstN;
    logic [wordWidth-1:0] iAddr, iData;
    logic                 dRead, dWrite;
    logic [wordWidth-1:0] dAddr, dWdata, dRdata;
    logic [wordWidth-1:0] outputPort;
    logic                 outputValid;
    logic [wordWidth-1:0] numInst;
    logic                 halted;

    logic [wordWidth-1:0] imem [64];
    logic [wordWidth-1:0] dmem [64];
    logic [wordWidth-1:0] expQ [$];
    logic [wordWidth-1:0] expHead;
    logic                 haveExp;
    int                   outIdx;
    int                   errorCount;
    int                   timeoutCount;
    int                   cycles;

    cpuTop #(.resetPc('0)) u_cpuTop (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // zero-wait memories
    assign iData  = imem[iAddr[5:0]];
    assign dRdata = dRead ? dmem[dAddr[5:0]] : '0;  // data only while dRead

    always @(posedge clk) begin
        if (dWrite) begin
            dmem[dAddr[5:0]] <= dWdata;
        end
    end

    function automatic logic [15:0] rType(input regIdx rs, rt, rd, input funcE fn);
        return {opRtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] iType(input opcodeE op, input regIdx rs, rt,
                                          input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {4'hF, i[5:0], 6'h3F};  // unused func decodes as a bubble
            dmem[i] = '0;
        end
        imem[0]  = iType(opLhi, 0, 1, 8'h12);       // r1 = 0x1200
        imem[1]  = iType(opAdi, 1, 1, 8'h34);       // r1 = 0x1234 at distance one
        imem[2]  = iType(opAdi, 0, 2, 8'hFD);       // r2 = -3
        imem[3]  = rType(1, 0, 0, fnWwd);           // distance two on r1
        imem[4]  = rType(1, 2, 3, fnAdd);
        imem[5]  = rType(3, 0, 0, fnWwd);
        imem[6]  = rType(1, 2, 3, fnSub);
        imem[7]  = rType(3, 0, 0, fnWwd);
        imem[8]  = rType(1, 2, 3, fnAnd);
        imem[9]  = rType(3, 0, 0, fnWwd);
        imem[10] = rType(1, 2, 3, fnOrr);
        imem[11] = rType(3, 0, 0, fnWwd);
        imem[12] = iType(opAdi, 0, 2, 8'd5);        // r2 = 5
        imem[13] = iType(opSwd, 2, 1, 8'd3);        // mem[8] = r1
        imem[14] = iType(opLwd, 2, 3, 8'd3);        // r3 = mem[8]
        imem[15] = rType(3, 3, 0, fnAdd);           // load use
        imem[16] = rType(0, 0, 0, fnWwd);
        imem[17] = iType(opBeq, 1, 1, 8'd1);        // taken
        imem[18] = rType(1, 0, 0, fnWwd);           // skipped
        imem[19] = iType(opBne, 1, 1, 8'd1);        // not taken
        imem[20] = rType(2, 0, 0, fnWwd);
        imem[21] = iType(opBne, 1, 2, 8'd1);        // taken
        imem[22] = rType(1, 0, 0, fnWwd);           // skipped
        imem[23] = {opJmp, 12'd25};
        imem[24] = rType(1, 0, 0, fnWwd);           // skipped
        imem[25] = rType(3, 0, 0, fnWwd);
        imem[26] = rType(0, 0, 0, fnHlt);
    endtask

    // expected WWD values in program order
    task automatic fillExpected();
        expQ.push_back(16'h1234);   // r1
        expQ.push_back(16'h1231);   // 0x1234 + 0xfffd
        expQ.push_back(16'h1237);   // 0x1234 - 0xfffd
        expQ.push_back(16'h1234);   // and
        expQ.push_back(16'hFFFD);   // or
        expQ.push_back(16'h2468);   // loaded 0x1234 doubled
        expQ.push_back(16'h0005);   // bne fall-through
        expQ.push_back(16'h1234);   // jmp target
    endtask

    // head of the queue settles between rising edges
    always @(negedge clk) begin
        haveExp = (outIdx < expQ.size());
        expHead = haveExp ? expQ[outIdx] : '0;
    end

    always @(posedge clk) begin
        if (rstN && outputValid) begin
            outIdx <= outIdx + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) outputValid |-> haveExp)
    else begin
        errorCount++;
        $display("output pulse at %0t with no expected value left", $time);
    end

    assert property (@(posedge clk) disable iff (!rstN)
                     outputValid && haveExp |-> outputPort == expHead)
    else begin
        errorCount++;
        $display("Error at %0t: outputPort got %h, expected %h", $time, outputPort, expHead);
    end

    // only one store in the program
    assert property (@(posedge clk) disable iff (!rstN)
                     dWrite |-> dAddr == 16'd8 && dWdata == 16'h1234)
    else begin
        errorCount++;
        $display("Error at %0t: dAddr/dWdata got %h/%h, expected 0008/1234",
                 $time, dAddr, dWdata);
    end

    initial begin
        rstN         = 1'b0;
        outIdx       = 0;
        errorCount   = 0;
        timeoutCount = 0;
        loadProgram();
        fillExpected();
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;

        cycles = 0;
        while (!halted && cycles < 500) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            timeoutCount++;
            $display("timed out after %0d cycles waiting for halted", cycles);
        end
        repeat (8) @(posedge clk);  // let the halt assertions run

        // 24 retire with skipped and bubble slots excluded
        assert (numInst == 16'd24)
        else begin
            errorCount++;
            $display("Error at %0t: numInst got %0d, expected 24", $time, numInst);
        end
        if (outIdx != expQ.size()) begin
            errorCount++;
            $display("only %0d of %0d expected outputs were seen", outIdx, expQ.size());
        end

        $display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/cpuTop_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTopProps (
    input logic clk,
    input logic rstN,
    input logic dRead,
    input logic dWrite,
    input logic outputValid,
    input logic halted
);

    // one memory access per cycle
    assert property (@(posedge clk) disable iff (!rstN) !(dRead && dWrite))
    else $error("dRead and dWrite high together");

    assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else $error("halted dropped without reset");

    // frozen after hlt
    assert property (@(posedge clk) disable iff (!rstN) halted |-> !dWrite && !outputValid)
    else $error("memory write or output pulse after halt");

    assert property (@(posedge clk)
                     !rstN |-> !dRead && !dWrite && !outputValid && !halted)
    else $error("control outputs active during reset");

endmodule

bind cpuTop cpuTopProps u_props (
    .clk,
    .rstN,
    .dRead,
    .dWrite,
    .outputValid,
    .halted
);

`default_nettype wire
